// ==== source/decode_pkg.sv ====
package decode_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    localparam int div_cycles = 8;  // busy time of one divide
    localparam int div_count_width = $clog2(div_cycles);

    localparam logic [reg_addr_width-1:0] link_reg_a = 5'd1;  // ra
    localparam logic [reg_addr_width-1:0] link_reg_b = 5'd5;  // t0, the alternate link

    // ########################################
    // opcode map

    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_auipc = 7'b0010111;
    localparam logic [6:0] opcode_jal = 7'b1101111;
    localparam logic [6:0] opcode_jalr = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt = 7'b0100000;  // sub and sra
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    localparam logic [xlen-1:0] instr_ecall = 32'h0000_0073;
    localparam logic [xlen-1:0] instr_ebreak = 32'h0010_0073;

    // ########################################
    // enumerations

    typedef enum logic [3:0] {
        class_alu, class_alu_imm, class_lui, class_auipc, class_jal, class_jalr,
        class_branch, class_load, class_store, class_mul, class_div, class_system,
        class_none
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and
    } alu_op_t;

    typedef enum logic [3:0] {
        except_none = 4'd0,
        except_illegal_instruction = 4'd2,
        except_breakpoint = 4'd3,
        except_env_call_mach = 4'd11
    } ecause_t;

    typedef enum logic [1:0] {state_run, state_bubble, state_div_wait} ctrl_state_t;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder import decode_pkg::*; (
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] imm,
    output logic [reg_addr_width-1:0] waddr,
    output logic [reg_addr_width-1:0] raddr1,
    output logic [reg_addr_width-1:0] raddr2,
    output logic wren,
    output logic rden1,
    output logic rden2,
    output op_class_t op_class,
    output alu_op_t alu_op,
    output logic ebreak,
    output logic ecall,
    output logic legal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic wr;
    alu_op_t funct_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign waddr = instr[11:7];
    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign wren = wr & legal & (waddr != '0);  // x0 is never written

    always_comb begin
        case (funct3)
            3'd0: funct_op = alu_add;  // sub is picked out by the register group
            3'd1: funct_op = alu_sll;
            3'd2: funct_op = alu_slt;
            3'd3: funct_op = alu_sltu;
            3'd4: funct_op = alu_xor;
            3'd5: funct_op = funct7[5] ? alu_sra : alu_srl;
            3'd6: funct_op = alu_or;
            default: funct_op = alu_and;
        endcase
    end

    always_comb begin
        imm = '0;
        wr = 1'b0;
        rden1 = 1'b0;
        rden2 = 1'b0;
        op_class = class_none;
        alu_op = alu_add;  // address and link arithmetic
        ecall = 1'b0;
        ebreak = 1'b0;
        legal = 1'b1;
        case (opcode)
            opcode_lui: begin
                op_class = class_lui;
                imm = imm_u;
                wr = 1'b1;
            end
            opcode_auipc: begin
                op_class = class_auipc;
                imm = imm_u;
                wr = 1'b1;
            end
            opcode_jal: begin
                op_class = class_jal;
                imm = imm_j;
                wr = 1'b1;
            end
            opcode_jalr: begin
                op_class = class_jalr;
                imm = imm_i;
                wr = 1'b1;
                rden1 = 1'b1;
                legal = (funct3 == 3'd0);
            end
            opcode_branch: begin
                op_class = class_branch;
                imm = imm_b;
                rden1 = 1'b1;
                rden2 = 1'b1;
                legal = (funct3[2:1] != 2'b01);
            end
            opcode_load: begin
                op_class = class_load;
                imm = imm_i;
                wr = 1'b1;
                rden1 = 1'b1;
                legal = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            end
            opcode_store: begin
                op_class = class_store;
                imm = imm_s;
                rden1 = 1'b1;
                rden2 = 1'b1;
                legal = funct3 inside {3'd0, 3'd1, 3'd2};
            end
            opcode_op_imm: begin
                op_class = class_alu_imm;
                imm = imm_i;
                wr = 1'b1;
                rden1 = 1'b1;
                alu_op = funct_op;
                if (funct3 == 3'd1) begin
                    legal = (funct7 == funct7_base);
                end else if (funct3 == 3'd5) begin
                    legal = (funct7 == funct7_base) || (funct7 == funct7_alt);
                end
            end
            opcode_op: begin
                wr = 1'b1;
                rden1 = 1'b1;
                rden2 = 1'b1;
                if (funct7 == funct7_muldiv) begin
                    op_class = funct3[2] ? class_div : class_mul;  // div, divu, rem, remu
                end else if (funct7 == funct7_base) begin
                    op_class = class_alu;
                    alu_op = funct_op;
                end else if (funct7 == funct7_alt && (funct3 == 3'd0 || funct3 == 3'd5)) begin
                    op_class = class_alu;
                    alu_op = (funct3 == 3'd0) ? alu_sub : alu_sra;
                end else begin
                    legal = 1'b0;
                end
            end
            opcode_system: begin
                op_class = class_system;
                ecall = (instr == instr_ecall);
                ebreak = (instr == instr_ebreak);
                legal = (instr == instr_ecall) || (instr == instr_ebreak);  // no csr access here
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            op_class = class_none;
            rden1 = 1'b0;
            rden2 = 1'b0;
        end
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/10ps

module register_file import decode_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic wren,
    input  logic [reg_addr_width-1:0] waddr,
    input  logic [xlen-1:0] wdata,
    input  logic rden1,
    input  logic [reg_addr_width-1:0] raddr1,
    input  logic rden2,
    input  logic [reg_addr_width-1:0] raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [1:31];  // x0 has no storage

    function automatic logic [xlen-1:0] read_port(
        input logic rden,
        input logic [reg_addr_width-1:0] raddr
    );
        if (!rden || raddr == '0) begin
            return '0;
        end
        if (wren && raddr == waddr) begin
            return wdata;  // write-through from the same cycle
        end
        return regs[raddr];
    endfunction

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wren && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(rden1, raddr1);
        rdata2 = read_port(rden2, raddr2);
    end

endmodule

// ==== source/divide_timer.sv ====
`timescale 1ns/10ps

module divide_timer import decode_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic done
);

    logic busy;
    logic [div_count_width-1:0] count;

    assign done = busy && (count == '0);  // high in the last busy cycle

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy <= 1'b1;
            count <= div_count_width'(div_cycles - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== source/issue_control.sv ====
`timescale 1ns/10ps

module issue_control import decode_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic flush,
    input  logic load_hazard,
    input  logic div_issue,
    input  logic div_done,
    output logic stall,
    output logic squash,
    output logic div_start
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            state_run, state_bubble: begin
                if (div_issue) begin
                    state_next = state_div_wait;
                end else if (load_hazard) begin
                    state_next = state_bubble;  // the held instruction goes next cycle
                end else begin
                    state_next = state_run;
                end
            end
            state_div_wait: begin
                if (div_done) begin
                    state_next = state_run;
                end
            end
            default: state_next = state_run;
        endcase
        if (flush) begin
            state_next = state_run;  // a redirect also ends a divide wait
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_run;
        end else begin
            state <= state_next;
        end
    end

    assign stall = !flush && (load_hazard || state == state_div_wait);
    assign squash = stall || flush;
    assign div_start = div_issue && (state != state_div_wait);

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import decode_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    input  logic [xlen-1:0] fetch_instr,
    output logic [xlen-1:0] instr,
    input  logic [xlen-1:0] dec_imm,
    input  logic [reg_addr_width-1:0] dec_waddr,
    input  logic [reg_addr_width-1:0] dec_raddr1,
    input  logic [reg_addr_width-1:0] dec_raddr2,
    input  logic dec_wren,
    input  logic dec_rden1,
    input  logic dec_rden2,
    input  op_class_t dec_class,
    input  alu_op_t dec_alu_op,
    input  logic dec_ebreak,
    input  logic dec_ecall,
    input  logic dec_legal,
    output logic [reg_addr_width-1:0] rf_raddr1,
    output logic [reg_addr_width-1:0] rf_raddr2,
    output logic rf_rden1,
    output logic rf_rden2,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic stall,
    input  logic squash,
    output logic load_hazard,
    output logic div_issue,
    output logic issue_valid,
    output logic [xlen-1:0] issue_pc,
    output logic [xlen-1:0] issue_npc,
    output logic [xlen-1:0] issue_imm,
    output logic [xlen-1:0] issue_rdata1,
    output logic [xlen-1:0] issue_rdata2,
    output logic [reg_addr_width-1:0] issue_waddr,
    output logic issue_wren,
    output op_class_t issue_class,
    output alu_op_t issue_alu_op,
    output logic issue_exception,
    output ecause_t issue_ecause,
    output logic [xlen-1:0] issue_etval,
    output logic return_push,
    output logic return_pop
);

    logic accept;
    logic link_waddr;
    logic link_raddr1;
    logic push;
    logic pop;
    logic exception;
    ecause_t ecause;

    assign instr = fetch_instr;
    assign rf_raddr1 = dec_raddr1;
    assign rf_raddr2 = dec_raddr2;
    assign rf_rden1 = fetch_valid && dec_rden1;
    assign rf_rden2 = fetch_valid && dec_rden2;

    assign accept = fetch_valid && !squash;
    assign div_issue = accept && dec_class == class_div;

    // the load in the issue register has its data only after execute
    assign load_hazard = issue_valid && issue_class == class_load && issue_waddr != '0
        && ((rf_rden1 && rf_raddr1 == issue_waddr) || (rf_rden2 && rf_raddr2 == issue_waddr));

    // ########################################
    // return-address stack hints

    always_comb begin
        link_waddr = (dec_waddr == link_reg_a) || (dec_waddr == link_reg_b);
        link_raddr1 = (dec_raddr1 == link_reg_a) || (dec_raddr1 == link_reg_b);
        push = 1'b0;
        pop = 1'b0;
        if (dec_class == class_jal) begin
            push = link_waddr;  // call, otherwise a plain jump
        end else if (dec_class == class_jalr) begin
            if (!link_waddr && link_raddr1) begin
                pop = 1'b1;
            end else if (link_waddr && !link_raddr1) begin
                push = 1'b1;
            end else if (link_waddr && link_raddr1) begin
                push = 1'b1;
                pop = (dec_waddr != dec_raddr1);  // coroutine swap
            end
        end
    end

    always_comb begin
        exception = 1'b1;
        if (!dec_legal) begin
            ecause = except_illegal_instruction;
        end else if (dec_ebreak) begin
            ecause = except_breakpoint;
        end else if (dec_ecall) begin
            ecause = except_env_call_mach;
        end else begin
            exception = 1'b0;
            ecause = except_none;
        end
    end

    // ########################################
    // issue register

    always_ff @(posedge clock) begin
        if (!reset) begin
            issue_valid <= 1'b0;
            issue_wren <= 1'b0;
            issue_exception <= 1'b0;
            return_push <= 1'b0;
            return_pop <= 1'b0;
            issue_pc <= '0;
            issue_npc <= '0;
            issue_imm <= '0;
            issue_rdata1 <= '0;
            issue_rdata2 <= '0;
            issue_waddr <= '0;
            issue_class <= class_none;
            issue_alu_op <= alu_add;
            issue_ecause <= except_none;
            issue_etval <= '0;
        end else begin
            issue_valid <= accept;  // a squashed slot leaves as a bubble
            issue_wren <= accept && dec_wren;
            issue_exception <= accept && exception;
            return_push <= accept && push;
            return_pop <= accept && pop;
            if (!stall) begin
                issue_pc <= fetch_pc;
                issue_npc <= fetch_pc + xlen'(4);
                issue_imm <= dec_imm;
                issue_rdata1 <= rdata1;
                issue_rdata2 <= rdata2;
                issue_waddr <= dec_waddr;
                issue_class <= dec_class;
                issue_alu_op <= dec_alu_op;
                issue_ecause <= ecause;
                issue_etval <= fetch_instr;
            end
        end
    end

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit import decode_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    input  logic [xlen-1:0] fetch_instr,
    input  logic flush,
    input  logic wb_wren,
    input  logic [reg_addr_width-1:0] wb_waddr,
    input  logic [xlen-1:0] wb_wdata,
    output logic stall,
    output logic issue_valid,
    output logic [xlen-1:0] issue_pc,
    output logic [xlen-1:0] issue_npc,
    output logic [xlen-1:0] issue_imm,
    output logic [xlen-1:0] issue_rdata1,
    output logic [xlen-1:0] issue_rdata2,
    output logic [reg_addr_width-1:0] issue_waddr,
    output logic issue_wren,
    output op_class_t issue_class,
    output alu_op_t issue_alu_op,
    output logic issue_exception,
    output ecause_t issue_ecause,
    output logic [xlen-1:0] issue_etval,
    output logic return_push,
    output logic return_pop
);

    logic [xlen-1:0] instr;
    logic [xlen-1:0] dec_imm;
    logic [reg_addr_width-1:0] dec_waddr;
    logic [reg_addr_width-1:0] dec_raddr1;
    logic [reg_addr_width-1:0] dec_raddr2;
    logic dec_wren;
    logic dec_rden1;
    logic dec_rden2;
    op_class_t dec_class;
    alu_op_t dec_alu_op;
    logic dec_ebreak;
    logic dec_ecall;
    logic dec_legal;
    logic [reg_addr_width-1:0] rf_raddr1;
    logic [reg_addr_width-1:0] rf_raddr2;
    logic rf_rden1;
    logic rf_rden2;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic squash;
    logic load_hazard;
    logic div_issue;
    logic div_start;
    logic div_done;

    instr_decoder u_instr_decoder (
        .instr,
        .imm(dec_imm),
        .waddr(dec_waddr),
        .raddr1(dec_raddr1),
        .raddr2(dec_raddr2),
        .wren(dec_wren),
        .rden1(dec_rden1),
        .rden2(dec_rden2),
        .op_class(dec_class),
        .alu_op(dec_alu_op),
        .ebreak(dec_ebreak),
        .ecall(dec_ecall),
        .legal(dec_legal)
    );

    register_file u_register_file (
        .clock,
        .reset,
        .wren(wb_wren),
        .waddr(wb_waddr),
        .wdata(wb_wdata),
        .rden1(rf_rden1),
        .raddr1(rf_raddr1),
        .rden2(rf_rden2),
        .raddr2(rf_raddr2),
        .rdata1,
        .rdata2
    );

    divide_timer u_divide_timer (
        .clock,
        .reset,
        .start(div_start),
        .done(div_done)
    );

    issue_control u_issue_control (
        .clock,
        .reset,
        .flush,
        .load_hazard,
        .div_issue,
        .div_done,
        .stall,
        .squash,
        .div_start
    );

    decode_stage u_decode_stage (.*);

endmodule

// ==== verif/decode_unit_properties.sv ====
`timescale 1ns/10ps

module decode_unit_properties import decode_pkg::*; (
    input logic clock,
    input logic reset,
    input logic flush,
    input logic stall,
    input logic issue_valid,
    input op_class_t issue_class,
    input logic return_pop,
    input logic div_issue
);

    int failures = 0;

    stall_low_after_reset: assert property (@(posedge clock) $rose(reset) |-> !stall)
        else begin
            failures++;
            $error("stall high in the first cycle after reset");
        end

    bubble_after_flush: assert property (@(posedge clock) disable iff (!reset)
        flush |=> !issue_valid)
        else begin
            failures++;
            $error("issue_valid high after a flush");
        end

    pop_only_on_jalr: assert property (@(posedge clock) disable iff (!reset)
        return_pop |-> issue_class == class_jalr)
        else begin
            failures++;
            $error("return_pop without a jalr");
        end

    // a flush inside the window cancels the wait
    divide_stall_length: assert property (@(posedge clock) disable iff (!reset || flush)
        div_issue |=> stall [*div_cycles] ##1 !stall)
        else begin
            failures++;
            $error("divide stall has the wrong length");
        end

endmodule

// ==== verif/tb_decode_unit.sv ====
`timescale 1ns/10ps

module tb_decode_unit import decode_pkg::*;;

    localparam int clock_period = 10;
    localparam int watchdog_cycles = 8 + 6 * (4 * div_cycles + 40);  // generous per test

    logic clock;
    logic reset;
    logic fetch_valid;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] fetch_instr;
    logic flush;
    logic wb_wren;
    logic [reg_addr_width-1:0] wb_waddr;
    logic [xlen-1:0] wb_wdata;
    logic stall;
    logic issue_valid;
    logic [xlen-1:0] issue_pc;
    logic [xlen-1:0] issue_npc;
    logic [xlen-1:0] issue_imm;
    logic [xlen-1:0] issue_rdata1;
    logic [xlen-1:0] issue_rdata2;
    logic [reg_addr_width-1:0] issue_waddr;
    logic issue_wren;
    op_class_t issue_class;
    alu_op_t issue_alu_op;
    logic issue_exception;
    ecause_t issue_ecause;
    logic [xlen-1:0] issue_etval;
    logic return_push;
    logic return_pop;

    logic [15:0] lfsr_state = 16'd34430;
    logic [xlen-1:0] x3_value;
    logic [xlen-1:0] x4_value;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_start_errors;

    decode_unit u_decode_unit (.*);

    bind decode_unit decode_unit_properties u_decode_unit_properties (.*);

    always #(clock_period / 2) clock = ~clock;

    // ########################################
    // helpers

    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic feedback;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] offset, input logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic present_instr(input logic [31:0] pc, input logic [31:0] word);
        fetch_valid = 1'b1;  // caller sits on a falling edge
        fetch_pc = pc;
        fetch_instr = word;
    endtask

    task automatic go_idle();
        fetch_valid = 1'b0;
        @(negedge clock);
    endtask

    task automatic writeback(input logic [4:0] addr, input logic [31:0] data);
        wb_wren = 1'b1;
        wb_waddr = addr;
        wb_wdata = data;
        @(negedge clock);
        wb_wren = 1'b0;
    endtask

    // counts stalled cycles and empty issue slots until something issues
    task automatic wait_for_issue(input int limit, output int stalls, output int bubbles);
        int cycle;
        bit seen;
        stalls = 0;
        bubbles = 0;
        cycle = 0;
        seen = 1'b0;
        while (!seen && cycle < limit) begin
            #1;
            if (stall) begin
                stalls++;
            end
            @(negedge clock);
            if (issue_valid) begin
                seen = 1'b1;
            end else begin
                bubbles++;
            end
            cycle++;
        end
        if (!seen) begin
            report_failure($sformatf("no instruction issued within %0d cycles", limit));
        end
    endtask

    // ########################################
    // tests

    task automatic register_alu_test();
        logic [11:0] imm12;
        test_start_errors = errors;
        x3_value = lfsr_bits(32);
        x4_value = lfsr_bits(32);
        imm12 = lfsr_bits(12);
        writeback(5'd3, x3_value);
        writeback(5'd4, x4_value);
        writeback(5'd0, lfsr_bits(32));  // must not land anywhere
        present_instr(32'h100, r_type_word(7'd0, 5'd4, 5'd3, 3'd0, 5'd5));
        @(negedge clock);
        check_value("issue_valid", issue_valid, 1);
        check_value("issue_rdata1", issue_rdata1, x3_value);
        check_value("issue_rdata2", issue_rdata2, x4_value);
        check_value("issue_class", issue_class, class_alu);
        check_value("issue_alu_op", issue_alu_op, alu_add);
        check_value("issue_waddr", issue_waddr, 5);
        check_value("issue_wren", issue_wren, 1);
        check_value("issue_npc", issue_npc, 32'h104);
        present_instr(32'h104, i_type_word(imm12, 5'd3, 3'd0, 5'd6, 7'b0010011));
        @(negedge clock);
        check_value("issue_rdata1", issue_rdata1, x3_value);
        check_value("issue_imm", issue_imm, {{20{imm12[11]}}, imm12});
        check_value("issue_class", issue_class, class_alu_imm);
        check_value("issue_waddr", issue_waddr, 6);
        check_value("issue_npc", issue_npc, 32'h108);
        present_instr(32'h108, r_type_word(7'd0, 5'd3, 5'd0, 3'd0, 5'd8));
        @(negedge clock);
        check_value("issue_rdata1", issue_rdata1, 0);
        check_value("issue_rdata2", issue_rdata2, x3_value);
        go_idle();
        finish_test("register and ALU decode");
    endtask

    task automatic check_exception(input logic [31:0] word, input logic [3:0] cause);
        present_instr(32'h200, word);
        @(negedge clock);
        check_value("issue_exception", issue_exception, 1);
        check_value("issue_ecause", issue_ecause, cause);
        check_value("issue_etval", issue_etval, word);
        check_value("issue_wren", issue_wren, 0);
    endtask

    task automatic exception_test();
        test_start_errors = errors;
        check_exception(32'h0000_0000, 4'd2);
        check_exception(32'h0010_0073, 4'd3);
        check_exception(32'h0000_0073, 4'd11);
        go_idle();
        finish_test("exceptions");
    endtask

    task automatic load_use_test();
        int stalls;
        int bubbles;
        test_start_errors = errors;
        present_instr(32'h300, i_type_word(12'd0, 5'd3, 3'd2, 5'd7, 7'b0000011));
        @(negedge clock);
        present_instr(32'h304, r_type_word(7'd0, 5'd4, 5'd7, 3'd0, 5'd9));
        wait_for_issue(4, stalls, bubbles);
        check_value("stall cycles", stalls, 1);
        check_value("bubble slots", bubbles, 1);
        check_value("issue_waddr", issue_waddr, 9);
        present_instr(32'h308, i_type_word(12'd0, 5'd3, 3'd2, 5'd7, 7'b0000011));
        @(negedge clock);
        present_instr(32'h30c, r_type_word(7'd0, 5'd4, 5'd3, 3'd0, 5'd10));
        wait_for_issue(4, stalls, bubbles);
        check_value("stall cycles", stalls, 0);
        check_value("issue_waddr", issue_waddr, 10);
        go_idle();
        finish_test("load-use hazard");
    endtask

    task automatic divide_wait_test();
        int stalls;
        int bubbles;
        test_start_errors = errors;
        present_instr(32'h400, r_type_word(7'd1, 5'd4, 5'd3, 3'd4, 5'd11));
        @(negedge clock);
        check_value("issue_class", issue_class, class_div);
        present_instr(32'h404, r_type_word(7'd0, 5'd4, 5'd3, 3'd0, 5'd12));
        wait_for_issue(div_cycles + 4, stalls, bubbles);
        check_value("stall cycles", stalls, div_cycles);
        check_value("bubble slots", bubbles, div_cycles);
        check_value("issue_waddr", issue_waddr, 12);
        go_idle();
        finish_test("divide wait");
    endtask

    task automatic flush_test();
        int stalls;
        int bubbles;
        test_start_errors = errors;
        present_instr(32'h500, r_type_word(7'd1, 5'd4, 5'd3, 3'd5, 5'd11));
        @(negedge clock);
        present_instr(32'h504, r_type_word(7'd0, 5'd4, 5'd3, 3'd0, 5'd13));
        @(negedge clock);
        check_value("stall", stall, 1);
        flush = 1'b1;
        #1;
        check_value("stall", stall, 0);
        @(negedge clock);
        flush = 1'b0;
        check_value("issue_valid", issue_valid, 0);
        present_instr(32'h600, r_type_word(7'd0, 5'd4, 5'd3, 3'd0, 5'd13));  // redirect target
        wait_for_issue(4, stalls, bubbles);
        check_value("stall cycles", stalls, 0);
        check_value("bubble slots", bubbles, 0);
        check_value("issue_pc", issue_pc, 32'h600);
        go_idle();
        finish_test("flush");
    endtask

    task automatic check_return(input logic [31:0] word, input op_class_t cls,
        input logic push, input logic pop);
        present_instr(32'h700, word);
        @(negedge clock);
        check_value("issue_class", issue_class, cls);
        check_value("return_push", return_push, push);
        check_value("return_pop", return_pop, pop);
    endtask

    task automatic return_class_test();
        test_start_errors = errors;
        check_return(jal_word(21'd16, 5'd1), class_jal, 1'b1, 1'b0);
        check_return(jal_word(21'd16, 5'd0), class_jal, 1'b0, 1'b0);
        check_return(i_type_word(12'd0, 5'd1, 3'd0, 5'd0, 7'b1100111), class_jalr, 1'b0, 1'b1);
        check_return(i_type_word(12'd0, 5'd6, 3'd0, 5'd1, 7'b1100111), class_jalr, 1'b1, 1'b0);
        check_return(i_type_word(12'd0, 5'd5, 3'd0, 5'd1, 7'b1100111), class_jalr, 1'b1, 1'b1);
        check_return(i_type_word(12'd0, 5'd5, 3'd0, 5'd5, 7'b1100111), class_jalr, 1'b1, 1'b0);
        go_idle();
        finish_test("return classification");
    endtask

    // ########################################
    // run

    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_instr = '0;
        flush = 1'b0;
        wb_wren = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;
        repeat (8) @(negedge clock);
        reset = 1'b1;
        check_value("stall", stall, 0);
        check_value("issue_valid", issue_valid, 0);
        register_alu_test();
        exception_test();
        load_use_test();
        divide_wait_test();
        flush_test();
        return_class_test();
        errors += u_decode_unit.u_decode_unit_properties.failures;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/decode_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/divide_timer.sv
source/issue_control.sv
source/decode_stage.sv
source/decode_unit.sv
verif/decode_unit_properties.sv
verif/tb_decode_unit.sv
